// ==== pal_pkg.sv ====
/*
 * Shared definitions for the palette stage of the arcade video board.
 * Holds the palette word format, the host register map, the palette
 * address union and the AXI4-Lite response codes.
 */

`default_nettype none

package pal_pkg;

    // ======================================================================
    // Widths
    // ======================================================================

    localparam int PAL_AW = 13;
    localparam int PAL_DW = 16;
    localparam int AXI_AW = 16;
    localparam int AXI_DW = 32;

    // One palette entry, which is also the RGB pixel leaving the stage
    typedef logic [PAL_DW-1:0] pal_word_t;

    // Object or playfield color code from the tile and sprite engines
    typedef logic [10:0] color_t;

    // The host sees the palette as eight banks of 1024 entries
    typedef struct packed {
        logic [2:0] bank;
        logic [9:0] index;
    } pal_host_addr_t;

    // Video side splits the address into half, bank and color code
    typedef struct packed {
        logic   pal_hi;
        logic   bank;
        color_t color;
    } pal_video_addr_t;

    typedef union packed {
        pal_host_addr_t  host;
        pal_video_addr_t video;
    } pal_addr_u;

    // ======================================================================
    // Host register map
    // ======================================================================

    localparam logic [AXI_AW-1:0] VID_CTRL_ADDR = 16'h0000;

    // Set for palette accesses, bits 14 to 2 then carry the palette index
    localparam int PAL_WINDOW_BIT = 15;

    // Bit positions in the video control word
    localparam int CTL_PAL_HI       = 15;
    localparam int CTL_PF_BANK      = 14;
    localparam int CTL_OBJ_BANK_OFF = 13;
    localparam int CTL_FORCE_BUS    = 12;
    localparam int CTL_OBJ_OFF      = 7;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== pal_bus_if.sv ====
/*
 * Carries palette accesses from the AXI4-Lite slave to the palette mixer.
 * The slave drives one-cycle requests through the host modport and the
 * mixer returns the unregistered RAM word through the palette modport.
 */

`timescale 1ns/1ps
`default_nettype none

interface pal_bus_if;

    // High for exactly one cycle per palette access
    logic req;

    // Write when high together with req, read otherwise
    logic we;

    // Keeps its last value while req is low
    pal_pkg::pal_addr_u addr;

    logic [pal_pkg::PAL_DW-1:0] wdata;

    // Combinational RAM output, valid in the same cycle as req
    logic [pal_pkg::PAL_DW-1:0] rdata;

    modport host (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport palette (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== pal_ram.sv ====
/*
 * Single-port palette RAM of 8192 words of 16 bits.
 * The write is synchronous and the read is unregistered, so the word at
 * the current address is available within the same cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module pal_ram (
    input  wire                 clk,
    input  pal_pkg::pal_addr_u  addr,
    input  wire                 we,
    input  pal_pkg::pal_word_t  wdata,
    output pal_pkg::pal_word_t  q
);

    // One entry per palette address
    pal_pkg::pal_word_t mem [2**pal_pkg::PAL_AW];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
    end

    // Read path feeds the pixel register and the host read capture
    assign q = mem[addr];

endmodule

`default_nettype wire

// ==== pal_mixer.sv ====
/*
 * Palette mixer. Picks one RAM address per cycle from the host bus, the
 * object color or the playfield color, forwards bus writes to the RAM and
 * registers the RAM word as the RGB pixel on the pixel enable.
 */

`timescale 1ns/1ps
`default_nettype none

module pal_mixer (
    input  wire                 clk,
    input  wire                 ce_pix,
    input  pal_pkg::pal_word_t  ctrl,
    pal_bus_if.palette          bus,

    input  pal_pkg::color_t     obj_color,
    input  wire                 obj_prio,
    input  wire                 obj_active,
    input  pal_pkg::color_t     pf_color,
    input  wire                 pf_prio,

    output pal_pkg::pal_addr_u  ram_addr,
    output logic                ram_we,
    output pal_pkg::pal_word_t  ram_wdata,
    input  pal_pkg::pal_word_t  ram_q,

    output pal_pkg::pal_word_t  rgb_out
);

    // ======================================================================
    // Source selection
    // ======================================================================

    logic obj_avail;
    logic obj_bank;
    logic obj_sel;
    logic bus_sel;
    pal_pkg::pal_addr_u obj_addr;
    pal_pkg::pal_addr_u pf_addr;

    // The object layer can be switched off as a whole
    assign obj_avail = obj_active && !ctrl[pal_pkg::CTL_OBJ_OFF];

    // Priority objects use the upper bank unless bank split is disabled
    assign obj_bank = obj_prio && !ctrl[pal_pkg::CTL_OBJ_BANK_OFF];

    // Host requests and the force bit both hand the RAM to the bus
    assign bus_sel = bus.req || ctrl[pal_pkg::CTL_FORCE_BUS];

    // A priority object beats the playfield when the bank split is off
    // or the playfield allows it; a plain object needs pf_prio
    assign obj_sel = obj_avail &&
                     ((obj_prio && (ctrl[pal_pkg::CTL_OBJ_BANK_OFF] || pf_prio)) ||
                      (!obj_prio && pf_prio));

    // ======================================================================
    // Address composition
    // ======================================================================

    always_comb begin
        obj_addr.video.pal_hi = ctrl[pal_pkg::CTL_PAL_HI];
        obj_addr.video.bank   = obj_bank;
        obj_addr.video.color  = obj_color;

        pf_addr.video.pal_hi  = ctrl[pal_pkg::CTL_PAL_HI];
        pf_addr.video.bank    = ctrl[pal_pkg::CTL_PF_BANK];
        pf_addr.video.color   = pf_color;
    end

    always_comb begin
        if (bus_sel)
            ram_addr = bus.addr;
        else if (obj_sel)
            ram_addr = obj_addr;
        else
            ram_addr = pf_addr;
    end

    // Forcing the bus without a request only reads the last bus address
    assign ram_we    = bus.req && bus.we;
    assign ram_wdata = bus.wdata;
    assign bus.rdata = ram_q;

    // ======================================================================
    // Pixel output
    // ======================================================================

    // One cycle from address selection to pixel
    always_ff @(posedge clk) begin
        if (ce_pix)
            rgb_out <= ram_q;
    end

endmodule

`default_nettype wire

// ==== pal_axi_slave.sv ====
/*
 * AXI4-Lite slave for the palette stage. Decodes each access into the
 * video control register, the palette window or an unmapped address, and
 * turns palette accesses into one-cycle requests on the palette bus.
 */

`timescale 1ns/1ps
`default_nettype none

module pal_axi_slave (
    input  wire                         clk,
    input  wire                         reset,

    // Write address, write data and write response channels
    input  wire  [pal_pkg::AXI_AW-1:0]  awaddr,
    input  wire                         awvalid,
    output logic                        awready,
    input  wire  [pal_pkg::AXI_DW-1:0]  wdata,
    input  wire  [3:0]                  wstrb,
    input  wire                         wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  wire                         bready,

    // Read address and read data channels
    input  wire  [pal_pkg::AXI_AW-1:0]  araddr,
    input  wire                         arvalid,
    output logic                        arready,
    output logic [pal_pkg::AXI_DW-1:0]  rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  wire                         rready,

    output pal_pkg::pal_word_t          ctrl,
    pal_bus_if.host                     bus
);

    // ======================================================================
    // Address decode
    // ======================================================================

    logic wr_hit_pal;
    logic wr_hit_ctrl;
    logic rd_hit_pal;
    logic rd_hit_ctrl;
    logic idle;
    logic wr_start;
    logic rd_start;
    pal_pkg::pal_addr_u wr_pal_addr;
    pal_pkg::pal_addr_u rd_pal_addr;

    assign wr_hit_pal  = awaddr[pal_pkg::PAL_WINDOW_BIT];
    assign rd_hit_pal  = araddr[pal_pkg::PAL_WINDOW_BIT];
    assign wr_hit_ctrl = awaddr[15:2] == pal_pkg::VID_CTRL_ADDR[15:2];
    assign rd_hit_ctrl = araddr[15:2] == pal_pkg::VID_CTRL_ADDR[15:2];

    // Bits 14 to 12 pick the bank and bits 11 to 2 the entry in it
    always_comb begin
        wr_pal_addr.host.bank  = awaddr[14:12];
        wr_pal_addr.host.index = awaddr[11:2];
        rd_pal_addr.host.bank  = araddr[14:12];
        rd_pal_addr.host.index = araddr[11:2];
    end

    // ======================================================================
    // Handshake control
    // ======================================================================

    // Only one access is in its handshake cycle at any time
    assign idle = !awready && !arready;

    // A pending response blocks a new access on its own channel
    assign wr_start = awvalid && wvalid && !bvalid && idle;

    // Writes win when both channels become ready together
    assign rd_start = arvalid && !rvalid && idle && !wr_start;

    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            bus.req <= 1'b0;
            ctrl    <= '0;
        end else begin
            awready <= wr_start;
            wready  <= wr_start;
            arready <= rd_start;

            // The palette request lines up with the ready cycle
            bus.req <= (wr_start && wr_hit_pal) || (rd_start && rd_hit_pal);

            if (bvalid && bready)
                bvalid <= 1'b0;
            else if (awready)
                bvalid <= 1'b1;

            if (rvalid && rready)
                rvalid <= 1'b0;
            else if (arready)
                rvalid <= 1'b1;

            // Control register takes byte strobes on its two bytes
            if (awready && wr_hit_ctrl) begin
                if (wstrb[0])
                    ctrl[7:0] <= wdata[7:0];
                if (wstrb[1])
                    ctrl[15:8] <= wdata[15:8];
            end
        end
    end

    // ======================================================================
    // Request payload and responses
    // ======================================================================

    always_ff @(posedge clk) begin
        if (wr_start) begin
            bus.we    <= 1'b1;
            bus.wdata <= wdata[pal_pkg::PAL_DW-1:0];
            if (wr_hit_pal)
                bus.addr <= wr_pal_addr;
        end else if (rd_start) begin
            bus.we <= 1'b0;
            if (rd_hit_pal)
                bus.addr <= rd_pal_addr;
        end

        // Unmapped writes are dropped and answered with SLVERR
        if (awready)
            bresp <= (wr_hit_pal || wr_hit_ctrl) ? pal_pkg::RESP_OKAY : pal_pkg::RESP_SLVERR;

        // Palette word is sampled while its request is on the bus
        if (arready) begin
            rresp <= pal_pkg::RESP_OKAY;
            if (rd_hit_pal)
                rdata <= {{(pal_pkg::AXI_DW-pal_pkg::PAL_DW){1'b0}}, bus.rdata};
            else if (rd_hit_ctrl)
                rdata <= {{(pal_pkg::AXI_DW-pal_pkg::PAL_DW){1'b0}}, ctrl};
            else begin
                rdata <= '0;
                rresp <= pal_pkg::RESP_SLVERR;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pal_video_top.sv ====
/*
 * Top level of the palette stage. Connects the AXI4-Lite slave, the
 * palette mixer and the palette RAM, and exposes the bus channels, the
 * color inputs and the RGB pixel as plain ports.
 */

`timescale 1ns/1ps
`default_nettype none

module pal_video_top (
    input  wire                         clk,
    input  wire                         reset,

    // AXI4-Lite host port
    input  wire  [pal_pkg::AXI_AW-1:0]  awaddr,
    input  wire                         awvalid,
    output logic                        awready,
    input  wire  [pal_pkg::AXI_DW-1:0]  wdata,
    input  wire  [3:0]                  wstrb,
    input  wire                         wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  wire                         bready,
    input  wire  [pal_pkg::AXI_AW-1:0]  araddr,
    input  wire                         arvalid,
    output logic                        arready,
    output logic [pal_pkg::AXI_DW-1:0]  rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  wire                         rready,

    // Pixel enable and colors from the tile and sprite engines
    input  wire                         ce_pix,
    input  pal_pkg::color_t             obj_color,
    input  wire                         obj_prio,
    input  wire                         obj_active,
    input  pal_pkg::color_t             pf_color,
    input  wire                         pf_prio,

    output pal_pkg::pal_word_t          rgb_out
);

    pal_pkg::pal_word_t ctrl;
    pal_pkg::pal_addr_u ram_addr;
    logic               ram_we;
    pal_pkg::pal_word_t ram_wdata;
    pal_pkg::pal_word_t ram_q;

    pal_bus_if i_pal_bus ();

    pal_axi_slave i_pal_axi_slave (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .ctrl    (ctrl),
        .bus     (i_pal_bus.host)
    );

    pal_mixer i_pal_mixer (
        .clk        (clk),
        .ce_pix     (ce_pix),
        .ctrl       (ctrl),
        .bus        (i_pal_bus.palette),
        .obj_color  (obj_color),
        .obj_prio   (obj_prio),
        .obj_active (obj_active),
        .pf_color   (pf_color),
        .pf_prio    (pf_prio),
        .ram_addr   (ram_addr),
        .ram_we     (ram_we),
        .ram_wdata  (ram_wdata),
        .ram_q      (ram_q),
        .rgb_out    (rgb_out)
    );

    pal_ram i_pal_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .q     (ram_q)
    );

endmodule

`default_nettype wire

// ==== pal_video_assertions.sv ====
/*
 * Concurrent checks on the AXI4-Lite handshakes and the palette request.
 * Bound to every pal_axi_slave instance, nothing else instantiates it.
 */

`timescale 1ns/1ps
`default_nettype none

module pal_video_assertions (
    input wire clk,
    input wire reset,
    input wire awready,
    input wire bvalid,
    input wire bready,
    input wire arready,
    input wire rvalid,
    input wire rready,
    input wire req
);

    // ======================================================================
    // Response channels
    // ======================================================================

    // A response stays up until the host takes it
    assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk) disable iff (reset) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // Back-pressure, a pending response blocks the next access on its channel
    assert property (@(posedge clk) disable iff (reset) bvalid |-> !awready)
        else $error("write accepted while bvalid was high");

    assert property (@(posedge clk) disable iff (reset) rvalid |-> !arready)
        else $error("read accepted while rvalid was high");

    // Palette requests are single-cycle pulses
    assert property (@(posedge clk) disable iff (reset) req |=> !req)
        else $error("palette request lasted more than one cycle");

endmodule

bind pal_axi_slave pal_video_assertions i_pal_video_assertions (
    .clk     (clk),
    .reset   (reset),
    .awready (awready),
    .bvalid  (bvalid),
    .bready  (bready),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready),
    .req     (bus.req)
);

`default_nettype wire

// ==== tb_pal_video.sv ====
/*
 * Testbench for the palette stage. Fills the palette over AXI4-Lite, then
 * checks register and palette accesses and the pixel path with LFSR
 * stimulus against a palette and control register model.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_pal_video;

    localparam int CLK_PERIOD = 100;
    localparam int N_ENTRIES  = 2**pal_pkg::PAL_AW;
    localparam int N_CTRL     = 40;
    localparam int N_PAL      = 200;
    localparam int N_UNMAP    = 20;
    localparam int N_PIX      = 400;
    localparam int N_FORCE    = 40;

    // Each access or pixel counts as one transaction with a bound of 20 cycles
    localparam int N_TRANS = N_ENTRIES + 2 * N_CTRL + 3 * N_PAL + 3 * N_UNMAP
                             + 3 * N_PIX + 4 * N_FORCE + 8;

    logic clk;
    logic reset;
    logic [pal_pkg::AXI_AW-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [pal_pkg::AXI_DW-1:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [pal_pkg::AXI_AW-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [pal_pkg::AXI_DW-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic ce_pix;
    pal_pkg::color_t obj_color;
    logic obj_prio;
    logic obj_active;
    pal_pkg::color_t pf_color;
    logic pf_prio;
    pal_pkg::pal_word_t rgb_out;

    // Model state
    pal_pkg::pal_word_t model_pal [N_ENTRIES];
    pal_pkg::pal_word_t model_ctrl;
    pal_pkg::pal_addr_u last_bus_addr;
    pal_pkg::pal_word_t last_pixel;
    logic [15:0] lfsr;

    pal_video_top i_pal_video_top (
        .clk        (clk),
        .reset      (reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .ce_pix     (ce_pix),
        .obj_color  (obj_color),
        .obj_prio   (obj_prio),
        .obj_active (obj_active),
        .pf_color   (pf_color),
        .pf_prio    (pf_prio),
        .rgb_out    (rgb_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ======================================================================
    // Error reporting and compare tasks
    // ======================================================================

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_word(input string name, input pal_pkg::pal_word_t actual,
                                input pal_pkg::pal_word_t expected);
        if (actual !== expected)
            stop_with_error($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                      $time, name, actual, expected));
    endtask

    task automatic compare_resp(input string name, input logic [1:0] actual,
                                input logic [1:0] expected);
        if (actual !== expected)
            stop_with_error($sformatf("Fail at %0t ns: %s is %b, expected %b",
                                      $time, name, actual, expected));
    endtask

    // ======================================================================
    // Random numbers
    // ======================================================================

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Takes n fresh bits, one LFSR step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // ======================================================================
    // AXI4-Lite host
    // ======================================================================

    // Every access is issued twice back to back. After the first handshake
    // the valids stay up for the second one, which has to wait while the
    // first response is held for a cycle with its ready low
    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] exp_resp);
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        for (int n = 0; n < 2; n++) begin
            do begin
                @(negedge clk);
            end while (!awready);
            if (!wready)
                stop_with_error("wready did not rise together with awready");
            if (n == 1) begin
                // The second handshake completes on this edge
                @(posedge clk);
                awvalid <= 1'b0;
                wvalid  <= 1'b0;
            end
            do begin
                @(negedge clk);
            end while (!bvalid);
            compare_resp("bresp", bresp, exp_resp);
            @(posedge clk);
            bready <= 1'b1;
            @(posedge clk);
            bready <= 1'b0;
        end
    endtask

    task automatic axi_read(input logic [15:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        for (int n = 0; n < 2; n++) begin
            do begin
                @(negedge clk);
            end while (!arready);
            if (n == 1) begin
                @(posedge clk);
                arvalid <= 1'b0;
            end
            do begin
                @(negedge clk);
            end while (!rvalid);
            compare_resp("rresp", rresp, exp_resp);
            compare_word("rdata[15:0]", rdata[15:0], exp_data[15:0]);
            compare_word("rdata[31:16]", rdata[31:16], exp_data[31:16]);
            @(posedge clk);
            rready <= 1'b1;
            @(posedge clk);
            rready <= 1'b0;
        end
    endtask

    // The palette window sets bit 15 and carries the host bank and index in bits 14 to 2
    function automatic logic [15:0] pal_byte_addr(input pal_pkg::pal_addr_u a);
        return {1'b1, a.host.bank, a.host.index, 2'b00};
    endfunction

    task automatic write_palette(input pal_pkg::pal_addr_u a, input pal_pkg::pal_word_t d);
        axi_write(pal_byte_addr(a), {16'h0000, d}, 4'hf, pal_pkg::RESP_OKAY);
        model_pal[a] = d;
        last_bus_addr = a;
    endtask

    task automatic check_palette(input pal_pkg::pal_addr_u a);
        axi_read(pal_byte_addr(a), {16'h0000, model_pal[a]}, pal_pkg::RESP_OKAY);
        last_bus_addr = a;
    endtask

    // Only the two low bytes of the control register exist
    task automatic write_ctrl(input logic [31:0] data, input logic [3:0] strb);
        axi_write(pal_pkg::VID_CTRL_ADDR, data, strb, pal_pkg::RESP_OKAY);
        if (strb[0])
            model_ctrl[7:0] = data[7:0];
        if (strb[1])
            model_ctrl[15:8] = data[15:8];
    endtask

    task automatic check_ctrl();
        axi_read(pal_pkg::VID_CTRL_ADDR, {16'h0000, model_ctrl}, pal_pkg::RESP_OKAY);
    endtask

    // ======================================================================
    // Pixel path model
    // ======================================================================

    // No bus request is pending during pixel checks, so only the force bit
    // can hand the RAM to the bus and the last bus address is read
    function automatic pal_pkg::pal_addr_u pixel_addr(input pal_pkg::pal_word_t c,
            input pal_pkg::color_t oc, input logic op, input logic oa,
            input pal_pkg::color_t pc, input logic pp);
        pal_pkg::pal_addr_u a;
        logic obj_wins;
        obj_wins = oa && !c[pal_pkg::CTL_OBJ_OFF] &&
                   (op ? (c[pal_pkg::CTL_OBJ_BANK_OFF] || pp) : pp);
        a.video.pal_hi = c[pal_pkg::CTL_PAL_HI];
        if (c[pal_pkg::CTL_FORCE_BUS]) begin
            a = last_bus_addr;
        end else if (obj_wins) begin
            a.video.bank  = op && !c[pal_pkg::CTL_OBJ_BANK_OFF];
            a.video.color = oc;
        end else begin
            a.video.bank  = c[pal_pkg::CTL_PF_BANK];
            a.video.color = pc;
        end
        return a;
    endfunction

    // One pixel cycle; with ce_random the enable may stay low
    task automatic pixel_check(input logic objects_on, input logic ce_random);
        logic [31:0] r;
        logic ce;
        logic active;
        pal_pkg::pal_addr_u a;
        pal_pkg::pal_word_t expected;
        r = rand_bits(26);
        ce = ce_random ? r[25] : 1'b1;
        active = objects_on && r[23];
        a = pixel_addr(model_ctrl, r[10:0], r[22], active, r[21:11], r[24]);
        expected = ce ? model_pal[a] : last_pixel;
        @(posedge clk);
        obj_color  <= r[10:0];
        pf_color   <= r[21:11];
        obj_prio   <= r[22];
        obj_active <= active;
        pf_prio    <= r[24];
        ce_pix     <= ce;
        // rgb_out loads at this edge when the enable was high
        @(posedge clk);
        ce_pix <= 1'b0;
        @(negedge clk);
        compare_word("rgb_out", rgb_out, expected);
        last_pixel = expected;
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        #(N_TRANS * 20 * CLK_PERIOD);
        stop_with_error("Watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] r;
        logic [15:0] addr;
        pal_pkg::pal_addr_u a;

        lfsr = 16'd47263;
        model_ctrl = '0;
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        ce_pix = 1'b0;
        obj_color = '0;
        obj_prio = 1'b0;
        obj_active = 1'b0;
        pf_color = '0;
        pf_prio = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Fill the whole palette so every pixel address has a known word
        for (int i = 0; i < N_ENTRIES; i++) begin
            a = i[12:0];
            r = rand_bits(16);
            write_palette(a, r[15:0]);
        end

        // Control register with random strobes
        for (int i = 0; i < N_CTRL; i++) begin
            r = rand_bits(20);
            write_ctrl({12'h000, r[19:0]}, r[19:16]);
            check_ctrl();
        end

        // Palette writes and reads at random indexes
        for (int i = 0; i < N_PAL; i++) begin
            r = rand_bits(29);
            a = r[28:16];
            write_palette(a, r[15:0]);
            check_palette(a);
            r = rand_bits(13);
            a = r[12:0];
            check_palette(a);
        end

        // Unmapped addresses lie between the register and the palette window
        for (int i = 0; i < N_UNMAP; i++) begin
            r = rand_bits(13);
            if (r[12:0] == 13'd0)
                r[0] = 1'b1;
            addr = {1'b0, r[12:0], 2'b00};
            axi_write(addr, rand_bits(32), 4'hf, pal_pkg::RESP_SLVERR);
            axi_read(addr, 32'h0000_0000, pal_pkg::RESP_SLVERR);
            check_ctrl();
        end

        // Playfield only with the force bit kept clear
        for (int i = 0; i < N_PIX; i++) begin
            if (i % 16 == 0) begin
                r = rand_bits(16);
                r[pal_pkg::CTL_FORCE_BUS] = 1'b0;
                write_ctrl(r, 4'b0011);
            end
            pixel_check(1'b0, 1'b0);
        end

        // Objects, priorities, control bits and the enable all random
        for (int i = 0; i < N_PIX; i++) begin
            if (i % 8 == 0)
                write_ctrl(rand_bits(16), 4'b0011);
            pixel_check(1'b1, 1'b1);
        end

        // Forced bus selection shows the word at the last bus address
        r = rand_bits(16);
        r[pal_pkg::CTL_FORCE_BUS] = 1'b1;
        write_ctrl(r, 4'b0011);
        for (int i = 0; i < N_FORCE; i++) begin
            r = rand_bits(13);
            a = r[12:0];
            check_palette(a);
            pixel_check(1'b1, 1'b0);
            pixel_check(1'b1, 1'b1);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
pal_pkg.sv
pal_bus_if.sv
pal_ram.sv
pal_mixer.sv
pal_axi_slave.sv
pal_video_top.sv
pal_video_assertions.sv
tb_pal_video.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_pal_video
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, the simulator status alone is not trusted
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
